// ==== hw/collision_matrix.sv ====
////////////////////////////////////////
// overlap rules for one pixel, purely combinational
// events follow the requests in the same cycle
////////////////////////////////////////

module collision_matrix import game_pkg::*; (
	draw_req_if.dst req,
	collision_if.src raw
);

	logic blast_any;     // either player's blast covers the pixel
	logic enemy_any;     // at least one enemy covers the pixel
	logic enemy_stop;    // obstacle for enemies
	logic p1_stop;
	logic p2_stop;
	logic p1_danger;
	logic p2_danger;

	assign blast_any = req.blast || req.blast2;
	assign enemy_any = |req.enemy;

	// each player walks through its own bomb but not the other's
	assign p1_stop = req.columns || req.wall || req.bomb2;
	assign p2_stop = req.columns || req.wall || req.bomb;

	// enemies are stopped by any bomb
	assign enemy_stop = req.columns || req.wall || req.bomb || req.bomb2;

	// blasts hurt both players, including the owner
	assign p1_danger = blast_any || enemy_any || req.spikes;
	assign p2_danger = blast_any || enemy_any || req.spikes;

	// blocking
	assign raw.player_block  = req.player && p1_stop;
	assign raw.player2_block = req.player2 && p2_stop;
	assign raw.enemy_block   = req.enemy & {NUM_ENEMIES{enemy_stop}};

	// a blast only breaks plain wall, columns are solid
	assign raw.blast_wall = blast_any && req.wall && !req.columns;

	// pick-ups hidden behind wall do not count
	assign raw.player_door      = req.player && req.door_idol && !req.wall;
	assign raw.player_power_up  = req.player && req.power_up && !req.wall;
	assign raw.player2_power_up = req.player2 && req.power_up && !req.wall;

	// hits are masked while the player is invulnerable
	assign raw.player_hit  = req.player && p1_danger && !req.player_invulnerable;
	assign raw.player2_hit = req.player2 && p2_danger && !req.player2_invulnerable;

	assign raw.enemy_kill = req.enemy & {NUM_ENEMIES{blast_any}}; // per enemy

endmodule

// ==== hw/draw_req_if.sv ====
////////////////////////////////////////
// sprite request bus and collision event bus
// collision_if is used for raw events and for frame pulses
////////////////////////////////////////

// drawing requests of all layers for the current pixel
interface draw_req_if import game_pkg::*; ();
	logic player;
	logic player2;
	logic columns;
	logic wall;
	logic blast;
	logic blast2;
	logic bomb;
	logic bomb2;
	logic door_idol;
	logic power_up;
	logic spikes;
	enemy_vec_t enemy;
	logic player_invulnerable; // level from the player's timer
	logic player2_invulnerable;

	modport src (
		output player, player2, columns, wall, blast, blast2, bomb, bomb2,
		output door_idol, power_up, spikes, enemy,
		output player_invulnerable, player2_invulnerable
	);

	modport dst (
		input player, player2, columns, wall, blast, blast2, bomb, bomb2,
		input door_idol, power_up, spikes, enemy,
		input player_invulnerable, player2_invulnerable
	);
endinterface

// named collision events, one bit each (enemy fields one bit per enemy)
interface collision_if import game_pkg::*; ();
	logic player_block;
	logic player2_block;
	enemy_vec_t enemy_block;
	logic blast_wall;
	logic player_hit;
	logic player2_hit;
	enemy_vec_t enemy_kill;
	logic player_power_up;
	logic player2_power_up;
	logic player_door;

	modport src (
		output player_block, player2_block, enemy_block, blast_wall,
		output player_hit, player2_hit, enemy_kill,
		output player_power_up, player2_power_up, player_door
	);

	modport dst (
		input player_block, player2_block, enemy_block, blast_wall,
		input player_hit, player2_hit, enemy_kill,
		input player_power_up, player2_power_up, player_door
	);
endinterface

// ==== hw/frame_hit_latch.sv ====
////////////////////////////////////////
// one pulse per event bit per frame, one cycle after the first hit
// blocking events are only delayed a cycle, never suppressed
////////////////////////////////////////

module frame_hit_latch import game_pkg::*; (
	input  logic clk,
	input  logic resetN,
	input  logic start_of_frame, // one cycle strobe per video frame
	collision_if.dst raw,
	collision_if.src pulse
);

	// suppressed events: blast_wall, hits, kills, power-ups, door
	localparam int EV_W = NUM_ENEMIES + 6;

	logic [EV_W-1:0] raw_vec;
	logic [EV_W-1:0] pulse_vec;
	logic [EV_W-1:0] flags;     // set once the bit has pulsed this frame
	logic [EV_W-1:0] flags_eff; // flags as seen by the current cycle

	logic player_block_q;
	logic player2_block_q;
	enemy_vec_t enemy_block_q;

	assign raw_vec = {
		raw.blast_wall,
		raw.player_hit,
		raw.player2_hit,
		raw.enemy_kill,
		raw.player_power_up,
		raw.player2_power_up,
		raw.player_door
	};

	// a new frame clears the flags in the same cycle,
	// so an event on the strobe belongs to the new frame
	assign flags_eff = start_of_frame ? '0 : flags;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			flags     <= '0;
			pulse_vec <= '0;
		end else begin
			pulse_vec <= raw_vec & ~flags_eff; // first occurrence only
			flags     <= flags_eff | raw_vec;
		end
	end

	// motion logic needs every blocked pixel
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			player_block_q  <= 1'b0;
			player2_block_q <= 1'b0;
			enemy_block_q   <= '0;
		end else begin
			player_block_q  <= raw.player_block;
			player2_block_q <= raw.player2_block;
			enemy_block_q   <= raw.enemy_block;
		end
	end

	assign {
		pulse.blast_wall,
		pulse.player_hit,
		pulse.player2_hit,
		pulse.enemy_kill,
		pulse.player_power_up,
		pulse.player2_power_up,
		pulse.player_door
	} = pulse_vec;

	assign pulse.player_block  = player_block_q;
	assign pulse.player2_block = player2_block_q;
	assign pulse.enemy_block   = enemy_block_q;

endmodule

// ==== hw/game_core.sv ====
////////////////////////////////////////
// collision and score top, requests to pulses 1 cycle, to counters 2
////////////////////////////////////////

module game_core import game_pkg::*; #(
	parameter int LIVES_INIT = 3 // lives per player at reset
) (
	input  logic clk,
	input  logic resetN,
	input  logic start_of_frame,
	input  logic player_req,
	input  logic player2_req,
	input  logic columns_req,
	input  logic wall_req,
	input  logic blast_req,
	input  logic blast2_req,
	input  logic bomb_req,
	input  logic bomb2_req,
	input  logic door_idol_req,
	input  logic power_up_req,
	input  logic spikes_req,
	input  enemy_vec_t enemy_req,
	input  logic player_invulnerable,
	input  logic player2_invulnerable,
	output logic player_block,
	output logic player2_block,
	output enemy_vec_t enemy_block,
	output logic blast_wall_pulse,
	output logic player_hit_pulse,
	output logic player2_hit_pulse,
	output enemy_vec_t enemy_kill_pulse,
	output lives_t lives1,
	output lives_t lives2,
	output count_t kills,
	output count_t power_ups1,
	output count_t power_ups2,
	output logic level_done,
	output logic game_over
);

	draw_req_if req_bus ();
	collision_if raw_bus ();   // same-cycle events
	collision_if pulse_bus (); // registered, one per frame

	assign req_bus.player               = player_req;
	assign req_bus.player2              = player2_req;
	assign req_bus.columns              = columns_req;
	assign req_bus.wall                 = wall_req;
	assign req_bus.blast                = blast_req;
	assign req_bus.blast2               = blast2_req;
	assign req_bus.bomb                 = bomb_req;
	assign req_bus.bomb2                = bomb2_req;
	assign req_bus.door_idol            = door_idol_req;
	assign req_bus.power_up             = power_up_req;
	assign req_bus.spikes               = spikes_req;
	assign req_bus.enemy                = enemy_req;
	assign req_bus.player_invulnerable  = player_invulnerable;
	assign req_bus.player2_invulnerable = player2_invulnerable;

	collision_matrix matrix_i (
		.req (req_bus.dst),
		.raw (raw_bus.src)
	);

	frame_hit_latch latch_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.raw            (raw_bus.dst),
		.pulse          (pulse_bus.src)
	);

	score_keeper #(
		.LIVES_INIT (LIVES_INIT)
	) score_i (
		.clk        (clk),
		.resetN     (resetN),
		.pulse      (pulse_bus.dst),
		.lives1     (lives1),
		.lives2     (lives2),
		.kills      (kills),
		.power_ups1 (power_ups1),
		.power_ups2 (power_ups2),
		.level_done (level_done),
		.game_over  (game_over)
	);

	// outputs straight from the pulse bus
	assign player_block      = pulse_bus.player_block;
	assign player2_block     = pulse_bus.player2_block;
	assign enemy_block       = pulse_bus.enemy_block;
	assign blast_wall_pulse  = pulse_bus.blast_wall;
	assign player_hit_pulse  = pulse_bus.player_hit;
	assign player2_hit_pulse = pulse_bus.player2_hit;
	assign enemy_kill_pulse  = pulse_bus.enemy_kill;

endmodule

// ==== hw/game_pkg.sv ====
////////////////////////////////////////
// widths and vector types shared by the collision blocks
// enemy count is fixed here, one request bit per enemy sprite
////////////////////////////////////////

package game_pkg;

	// number of enemy sprites on screen
	localparam int NUM_ENEMIES = 3;

	localparam int LIVES_W = 3; // up to 7 lives per player
	localparam int COUNT_W = 8; // tallies saturate at 255

	// remaining lives of one player
	typedef logic [LIVES_W-1:0] lives_t;

	// kill and power-up tallies
	typedef logic [COUNT_W-1:0] count_t;

	// one bit per enemy sprite, bit i is enemy i
	typedef logic [NUM_ENEMIES-1:0] enemy_vec_t;

endpackage

// ==== hw/score_keeper.sv ====
////////////////////////////////////////
// lives and tallies, all saturating; counters move a cycle after a pulse
// level_done is sticky until reset
////////////////////////////////////////

module score_keeper import game_pkg::*; #(
	parameter int LIVES_INIT = 3 // must fit in lives_t
) (
	input  logic clk,
	input  logic resetN,
	collision_if.dst pulse,
	output lives_t lives1,
	output lives_t lives2,
	output count_t kills,
	output count_t power_ups1,
	output count_t power_ups2,
	output logic level_done,
	output logic game_over
);

	logic [COUNT_W:0] kill_sum; // one extra bit to catch overflow

	// number of enemies killed by this pulse
	function automatic count_t count_ones(input enemy_vec_t v);
		count_t n;
		n = '0;
		for (int i = 0; i < NUM_ENEMIES; i++)
			n = n + count_t'(v[i]);
		return n;
	endfunction

	assign kill_sum = {1'b0, kills} + {1'b0, count_ones(pulse.enemy_kill)};

	// lives
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lives1 <= lives_t'(LIVES_INIT);
			lives2 <= lives_t'(LIVES_INIT);
		end else begin
			if (pulse.player_hit && lives1 != '0)
				lives1 <= lives1 - 1'b1; // stop at zero
			if (pulse.player2_hit && lives2 != '0)
				lives2 <= lives2 - 1'b1;
		end
	end

	// kills and power-ups
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			kills      <= '0;
			power_ups1 <= '0;
			power_ups2 <= '0;
		end else begin
			if (kill_sum[COUNT_W])
				kills <= {COUNT_W{1'b1}}; // hold at max
			else
				kills <= kill_sum[COUNT_W-1:0];
			if (pulse.player_power_up && power_ups1 != {COUNT_W{1'b1}})
				power_ups1 <= power_ups1 + 1'b1;
			if (pulse.player2_power_up && power_ups2 != {COUNT_W{1'b1}})
				power_ups2 <= power_ups2 + 1'b1;
		end
	end

	// door reached, stays set for the rest of the level
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			level_done <= 1'b0;
		else if (pulse.player_door)
			level_done <= 1'b1;
	end

	assign game_over = (lives1 == '0) && (lives2 == '0);

endmodule

// ==== sim.f ====
hw/game_pkg.sv
hw/draw_req_if.sv
hw/collision_matrix.sv
hw/frame_hit_latch.sv
hw/score_keeper.sv
hw/game_core.sv
verification/game_core_sva.sv
verification/game_core_tb.sv

// ==== verification/game_core_sva.sv ====
////////////////////////////////////////
// pulse rules of frame_hit_latch, bound into every instance
////////////////////////////////////////

module game_core_sva #(
	parameter int EV_W = 9
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic [EV_W-1:0] raw_vec,
	input logic [EV_W-1:0] pulse_vec
);

	int fail_count = 0;
	logic [EV_W-1:0] pulsed; // bit has pulsed since the last strobe

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			pulsed <= '0;
		else if (start_of_frame)
			pulsed <= '0;
		else
			pulsed <= pulsed | pulse_vec;
	end

	for (genvar i = 0; i < EV_W; i++) begin : g_bit
		// a strobe during a pulse opens a frame that may pulse again
		assert property (@(posedge clk) disable iff (!resetN)
			pulse_vec[i] && !start_of_frame |=> !pulse_vec[i])
		else begin
			fail_count++;
			$error("pulse bit %0d high for two cycles", i);
		end

		assert property (@(posedge clk) disable iff (!resetN)
			pulse_vec[i] |-> $past(raw_vec[i]))
		else begin
			fail_count++;
			$error("pulse bit %0d without a raw event", i);
		end

		assert property (@(posedge clk) disable iff (!resetN)
			pulse_vec[i] |-> !pulsed[i])
		else begin
			fail_count++;
			$error("second pulse of bit %0d in one frame", i);
		end
	end

endmodule

bind frame_hit_latch game_core_sva #(.EV_W(EV_W)) sva_i (
	.clk            (clk),
	.resetN         (resetN),
	.start_of_frame (start_of_frame),
	.raw_vec        (raw_vec),
	.pulse_vec      (pulse_vec)
);

// ==== verification/game_core_tb.sv ====
////////////////////////////////////////
// stimulus and checkpoints come from verification/game_core_testdata.txt
// run from the project root; pulses, blocks and counters are checked every cycle
////////////////////////////////////////

module game_core_tb import game_pkg::*; ();

	localparam int LIVES_INIT = 3;
	localparam int RAND_CYCLES = 200;
	localparam string DATA_FILE = "verification/game_core_testdata.txt";

	logic clk = 1'b0;
	logic resetN;
	logic start_of_frame;
	logic player_req, player2_req;
	logic columns_req, wall_req, spikes_req;
	logic blast_req, blast2_req, bomb_req, bomb2_req;
	logic door_idol_req, power_up_req;
	enemy_vec_t enemy_req;
	logic player_invulnerable, player2_invulnerable;

	logic player_block, player2_block;
	enemy_vec_t enemy_block;
	logic blast_wall_pulse, player_hit_pulse, player2_hit_pulse;
	enemy_vec_t enemy_kill_pulse;
	lives_t lives1, lives2;
	count_t kills, power_ups1, power_ups2;
	logic level_done, game_over;

	int seed = 38783;
	int error_count = 0;
	int check_count = 0;
	int tests_done = 0;
	int timeout_cycles = 0;

	// reference model state
	logic exp_block1;
	logic exp_block2;
	enemy_vec_t exp_eblock;
	logic [NUM_ENEMIES+5:0] exp_events; // pick-ups and door above blast_wall, hits and kills
	logic [NUM_ENEMIES+5:0] frame_seen; // events already pulsed in this frame

	// expected counters, one cycle behind the expected pulses
	lives_t ref_lives1;
	lives_t ref_lives2;
	count_t ref_kills;
	count_t ref_pu1;
	count_t ref_pu2;
	logic ref_done;

	game_core #(.LIVES_INIT(LIVES_INIT)) game_core_i (.*);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("mismatch at %0t: %0s expected %0h, got %0h", $time, name, expected,
				actual);
		end
	endtask

	task automatic flag_bad_line(input string kind);
		error_count++;
		$display("malformed %0s line in the test data file", kind);
	endtask

	task automatic set_inputs(input logic sof, input logic [1:0] pp, input logic [2:0] ter,
			input logic [3:0] weap, input logic [1:0] item, input enemy_vec_t en,
			input logic [1:0] inv);
		start_of_frame       <= sof;
		player_req           <= pp[1];
		player2_req          <= pp[0];
		columns_req          <= ter[2];
		wall_req             <= ter[1];
		spikes_req           <= ter[0];
		blast_req            <= weap[3];
		blast2_req           <= weap[2];
		bomb_req             <= weap[1];
		bomb2_req            <= weap[0];
		door_idol_req        <= item[1];
		power_up_req         <= item[0];
		enemy_req            <= en;
		player_invulnerable  <= inv[1];
		player2_invulnerable <= inv[0];
	endtask

	// overlap rules, then one pulse per event per frame
	task automatic predict(input logic sof, input logic [1:0] pp, input logic [2:0] ter,
			input logic [3:0] weap, input logic [1:0] item, input enemy_vec_t en,
			input logic [1:0] inv);
		logic blast_any;
		logic danger;
		logic [NUM_ENEMIES+5:0] events;
		blast_any = weap[3] | weap[2];
		danger = blast_any | (|en) | ter[0];
		exp_block1 = pp[1] & (ter[2] | ter[1] | weap[0]);
		exp_block2 = pp[0] & (ter[2] | ter[1] | weap[1]);
		exp_eblock = (ter[2] | ter[1] | weap[1] | weap[0]) ? en : '0;
		events = {pp[1] & item[0] & ~ter[1], pp[0] & item[0] & ~ter[1],
			pp[1] & item[1] & ~ter[1], blast_any & ter[1] & ~ter[2],
			pp[1] & danger & ~inv[1], pp[0] & danger & ~inv[0],
			blast_any ? en : enemy_vec_t'(0)};
		if (sof)
			frame_seen = '0; // strobe opens the new frame
		exp_events = events & ~frame_seen;
		frame_seen = frame_seen | events;
	endtask

	// counters move one cycle after the pulse, lives stop at 0 and tallies at 255
	task automatic count_pulses();
		int kill_sum;
		kill_sum = int'(ref_kills) + $countones(exp_events[NUM_ENEMIES-1:0]);
		ref_kills = (kill_sum > 255) ? 8'd255 : count_t'(kill_sum);
		if (exp_events[NUM_ENEMIES+1] && ref_lives1 != 0)
			ref_lives1 = ref_lives1 - 1;
		if (exp_events[NUM_ENEMIES] && ref_lives2 != 0)
			ref_lives2 = ref_lives2 - 1;
		if (exp_events[NUM_ENEMIES+5] && ref_pu1 != 255)
			ref_pu1 = ref_pu1 + 1;
		if (exp_events[NUM_ENEMIES+4] && ref_pu2 != 255)
			ref_pu2 = ref_pu2 + 1;
		if (exp_events[NUM_ENEMIES+3])
			ref_done = 1'b1; // sticky until reset
	endtask

	task automatic check_outputs();
		check_value("player_block", exp_block1, player_block);
		check_value("player2_block", exp_block2, player2_block);
		check_value("enemy_block", exp_eblock, enemy_block);
		check_value("blast_wall_pulse", exp_events[NUM_ENEMIES+2], blast_wall_pulse);
		check_value("player_hit_pulse", exp_events[NUM_ENEMIES+1], player_hit_pulse);
		check_value("player2_hit_pulse", exp_events[NUM_ENEMIES], player2_hit_pulse);
		check_value("enemy_kill_pulse", exp_events[NUM_ENEMIES-1:0], enemy_kill_pulse);
		check_value("lives1", ref_lives1, lives1);
		check_value("lives2", ref_lives2, lives2);
		check_value("kills", ref_kills, kills);
		check_value("power_ups1", ref_pu1, power_ups1);
		check_value("power_ups2", ref_pu2, power_ups2);
		check_value("level_done", ref_done, level_done);
		check_value("game_over", ref_lives1 == 0 && ref_lives2 == 0, game_over);
	endtask

	// outputs of the previous vector are stable at the falling edge
	task automatic drive_cycle(input logic sof, input logic [1:0] pp, input logic [2:0] ter,
			input logic [3:0] weap, input logic [1:0] item, input enemy_vec_t en,
			input logic [1:0] inv);
		@(posedge clk);
		set_inputs(sof, pp, ter, weap, item, en, inv);
		@(negedge clk);
		check_outputs();
		count_pulses();
		predict(sof, pp, ter, weap, item, en, inv);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		resetN <= 1'b0;
		set_inputs(1'b0, '0, '0, '0, '0, '0, '0);
		repeat (2) @(posedge clk);
		resetN <= 1'b1;
		exp_block1 = 1'b0;
		exp_block2 = 1'b0;
		exp_eblock = '0;
		exp_events = '0;
		frame_seen = '0;
		ref_lives1 = lives_t'(LIVES_INIT);
		ref_lives2 = lives_t'(LIVES_INIT);
		ref_kills = '0;
		ref_pu1 = '0;
		ref_pu2 = '0;
		ref_done = 1'b0;
	endtask

	task automatic run_random();
		logic [31:0] r;
		for (int i = 0; i < RAND_CYCLES; i++) begin
			r = $random(seed);
			drive_cycle(r[31:28] == 4'h0, r[1:0], r[4:2], r[8:5], r[10:9], r[13:11],
				r[15:14]); // about one strobe in 16 cycles
		end
	endtask

	initial begin
		logic [63:0] tag;
		logic [8*128-1:0] rest;
		logic [8*16-1:0] test_name;
		logic sof;
		logic [1:0] pp;
		logic [2:0] ter;
		logic [3:0] weap;
		logic [1:0] item;
		enemy_vec_t en;
		logic [1:0] inv;
		int fd;
		int n;
		int lines;
		int test_num;
		int errors_before;
		int exp_lives1, exp_lives2, exp_kills, exp_pu1, exp_pu2;
		int exp_done, exp_over;

		resetN <= 1'b0;
		set_inputs(1'b0, '0, '0, '0, '0, '0, '0);
		lines = 0;
		test_num = 0;
		errors_before = 0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("could not open the test data file %0s", DATA_FILE);
			error_count++;
		end else begin
			while ($fgets(rest, fd) != 0)
				lines++;
			$fclose(fd);
			timeout_cycles = lines + RAND_CYCLES + 50;
			fd = $fopen(DATA_FILE, "r");
			apply_reset();
			while ($fscanf(fd, "%s", tag) == 1) begin
				case (tag)
					"T": begin
						n = $fscanf(fd, "%d %s", test_num, test_name);
						if (n != 2)
							flag_bad_line("test header");
						errors_before = error_count;
					end
					"V": begin
						n = $fscanf(fd, "%b %b %b %b %b %b %b", sof, pp, ter, weap, item, en,
							inv);
						if (n == 7)
							drive_cycle(sof, pp, ter, weap, item, en, inv);
						else
							flag_bad_line("vector");
					end
					"C": begin
						n = $fscanf(fd, "%d %d %d %d %d %d %d", exp_lives1, exp_lives2,
							exp_kills, exp_pu1, exp_pu2, exp_done, exp_over);
						if (n != 7)
							flag_bad_line("checkpoint");
						repeat (2) drive_cycle(1'b0, '0, '0, '0, '0, '0, '0); // drain
						check_value("lives1", exp_lives1, lives1);
						check_value("lives2", exp_lives2, lives2);
						check_value("kills", exp_kills, kills);
						check_value("power_ups1", exp_pu1, power_ups1);
						check_value("power_ups2", exp_pu2, power_ups2);
						check_value("level_done", exp_done, level_done);
						check_value("game_over", exp_over, game_over);
					end
					"R": run_random();
					"X": apply_reset();
					"E": begin
						tests_done++;
						$display("test %0d %0s finished, %0d errors", test_num, test_name,
							error_count - errors_before);
					end
					"#": ;
					default: begin
						$display("unknown tag in the test data file");
						error_count++;
					end
				endcase
				n = $fgets(rest, fd); // rest of the line
			end
			$fclose(fd);
		end
		error_count += game_core_i.latch_i.sva_i.fail_count;
		$display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		wait (timeout_cycles > 0);
		#(timeout_cycles * 20);
		$display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verification/game_core_testdata.txt ====
# tags: T test name, V one cycle, C checkpoint, R random cycles, X reset, E end of test
# V: sof players(p1 p2) terrain(columns wall spikes) weapons(blast blast2 bomb bomb2)
#    items(door power_up) enemies(2..0) invulnerable(p1 p2)
# C: lives1 lives2 kills power_ups1 power_ups2 level_done game_over, after two idle cycles
T 1 blocking
V 1 00 000 0000 00 000 00 # frame start
V 0 10 100 0000 00 000 00 # p1 on columns
V 0 10 100 0000 00 000 00 # blocked again
V 0 01 000 0001 00 000 00 # p2 on its own bomb
V 0 01 000 0010 00 000 00 # p2 on bomb of p1
V 0 10 000 0010 00 000 00
V 0 00 010 0000 00 101 00 # enemies 0 and 2 on wall
V 0 00 000 0001 00 010 00
C 3 3 0 0 0 0 0
E
T 2 one_pulse
V 1 10 001 0000 00 000 00 # p1 on spikes
V 0 10 001 0000 00 000 00
V 0 10 001 0000 00 000 00
V 0 00 000 0000 00 000 00
V 1 11 001 0000 00 000 00 # hit on the strobe counts for the new frame
V 0 11 001 0000 00 000 00
C 1 2 0 0 0 0 0
E
T 3 masking
V 1 10 001 0000 00 000 10 # p1 invulnerable
V 0 01 000 1000 00 000 01 # p2 invulnerable
V 0 10 010 0000 11 000 00 # door and power-up behind wall
V 0 01 000 0000 01 000 00
V 0 10 000 0000 01 000 10
C 1 2 0 1 1 0 0
R
X
C 3 3 0 0 0 0 0
E
T 4 kills
V 1 00 000 1000 00 011 00 # blast over two enemies
V 0 00 000 0100 00 011 00
V 0 00 110 1000 00 000 00 # columns stop the blast
V 0 00 010 0100 00 000 00
V 1 00 000 0100 00 100 00
C 3 3 3 0 0 0 0
E
T 5 end_game
V 1 11 000 0000 00 001 00
V 1 11 000 0000 00 001 00
V 1 10 000 0000 00 001 00
C 0 1 3 0 0 0 0
V 1 10 001 0000 00 000 00 # lives stay at zero
V 1 01 001 0000 00 000 00
C 0 0 3 0 0 0 1
V 0 10 000 0000 10 000 00 # door reached
C 0 0 3 0 0 1 1
V 1 00 000 0000 00 000 00
C 0 0 3 0 0 1 1
X
C 3 3 0 0 0 0 0
E
